// File: design/rvIsaPkg.sv
package rvIsaPkg;

	// Instruction word width
	localparam int ILEN = 32;

	// Field widths
	localparam int OPC_W = 7;
	localparam int F3_W = 3;
	localparam int F7_W = 7;

	// Field positions, low bit of each field
	localparam int OPC_LSB = 0;
	localparam int RD_LSB = 7;
	localparam int F3_LSB = 12;
	localparam int RS1_LSB = 15;
	localparam int RS2_LSB = 20;
	localparam int F7_LSB = 25;

	// Major opcodes
	localparam logic [OPC_W-1:0] OPC_RTYPE = 7'b0110011;
	localparam logic [OPC_W-1:0] OPC_OPIMM = 7'b0010011;
	localparam logic [OPC_W-1:0] OPC_LOAD = 7'b0000011;
	localparam logic [OPC_W-1:0] OPC_STORE = 7'b0100011;

	// funct3 codes
	localparam logic [F3_W-1:0] F3_ADDSUB = 3'b000;
	localparam logic [F3_W-1:0] F3_OR = 3'b110;
	localparam logic [F3_W-1:0] F3_AND = 3'b111;

	// funct7 for sub
	localparam logic [F7_W-1:0] F7_SUB = 7'b0100000;

	// Opcode zero decodes to nothing
	localparam logic [ILEN-1:0] NOP_INSTR = '0;

endpackage

// File: design/rvCorePkg.sv
package rvCorePkg;

	localparam int XLEN = 32;
	localparam int REG_IDX_W = 5;

	// Coarse ALU operation from the main decoder
	typedef enum logic [1:0] {
		ALUOP_ADD = 2'b00,
		ALUOP_IMM = 2'b01,
		ALUOP_RTYPE = 2'b10
	} aluOpT;

	// ALU function select
	typedef enum logic [3:0] {
		ALU_AND = 4'b0000,
		ALU_OR = 4'b0001,
		ALU_ADD = 4'b0010,
		ALU_SUB = 4'b0110
	} aluCtrlT;

	// Operand source in EX
	typedef enum logic [1:0] {
		FWD_REG = 2'b00,
		FWD_WB = 2'b01,
		FWD_MEM = 2'b10
	} fwdSelT;

endpackage

// File: design/rvFrontEnd.sv
`timescale 1ns/1ps

module rvFrontEnd #(
	parameter int IMEM_DEPTH = 64
) (
	input  logic clk,
	input  logic i_reset,
	input  logic i_run,
	input  logic i_loadEn,
	input  logic [$clog2(IMEM_DEPTH)-1:0] i_loadAddr,
	input  logic [rvCorePkg::XLEN-1:0] i_loadData,
	input  logic i_exMemRead,
	input  logic [rvCorePkg::REG_IDX_W-1:0] i_exRd,
	output logic [rvCorePkg::REG_IDX_W-1:0] o_rs1,
	output logic [rvCorePkg::REG_IDX_W-1:0] o_rs2,
	output logic [rvCorePkg::REG_IDX_W-1:0] o_rd,
	output logic [rvCorePkg::XLEN-1:0] o_imm,
	output logic [rvCorePkg::XLEN-1:0] o_instr,
	output rvCorePkg::aluOpT o_aluOp,
	output logic o_aluSrc,
	output logic o_memRead,
	output logic o_memWrite,
	output logic o_regWrite,
	output logic o_memToReg
);

	localparam int IMEM_AW = $clog2(IMEM_DEPTH);

	logic [rvCorePkg::XLEN-1:0] imem [IMEM_DEPTH];
	logic [rvCorePkg::XLEN-1:0] pc;
	logic [IMEM_AW-1:0] fetchIdx;
	logic [rvCorePkg::XLEN-1:0] ifIdInstr;
	logic [rvIsaPkg::OPC_W-1:0] opcode;

	rvCorePkg::aluOpT ctlAluOp;
	logic ctlAluSrc;
	logic ctlMemRead;
	logic ctlMemWrite;
	logic ctlRegWrite;
	logic ctlMemToReg;
	logic useRs1;
	logic useRs2;
	logic stall;

	// Program load port
	always_ff @(posedge clk)
	begin
		if (i_loadEn)
			imem[i_loadAddr] <= i_loadData;
	end

	// Word index, wraps at the memory depth
	assign fetchIdx = IMEM_AW'((pc >> 2) % IMEM_DEPTH);

	// PC and IF/ID, both frozen by a load-use stall
	always_ff @(posedge clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			pc <= '0;
			ifIdInstr <= rvIsaPkg::NOP_INSTR;
		end
		else if (!i_run)
		begin
			pc <= '0;
			ifIdInstr <= rvIsaPkg::NOP_INSTR;
		end
		else if (!stall)
		begin
			pc <= pc + rvCorePkg::XLEN'(4);
			ifIdInstr <= imem[fetchIdx];
		end
	end

	assign opcode = ifIdInstr[rvIsaPkg::OPC_LSB +: rvIsaPkg::OPC_W];
	assign o_instr = ifIdInstr;
	assign o_rs1 = ifIdInstr[rvIsaPkg::RS1_LSB +: rvCorePkg::REG_IDX_W];
	assign o_rs2 = ifIdInstr[rvIsaPkg::RS2_LSB +: rvCorePkg::REG_IDX_W];
	assign o_rd = ifIdInstr[rvIsaPkg::RD_LSB +: rvCorePkg::REG_IDX_W];

	// Main decoder, unknown opcodes leave everything off
	always_comb
	begin
		ctlAluOp = rvCorePkg::ALUOP_ADD;
		ctlAluSrc = 1'b0;
		ctlMemRead = 1'b0;
		ctlMemWrite = 1'b0;
		ctlRegWrite = 1'b0;
		ctlMemToReg = 1'b0;
		useRs1 = 1'b0;
		useRs2 = 1'b0;
		case (opcode)
			rvIsaPkg::OPC_RTYPE:
			begin
				ctlAluOp = rvCorePkg::ALUOP_RTYPE;
				ctlRegWrite = 1'b1;
				useRs1 = 1'b1;
				useRs2 = 1'b1;
			end
			rvIsaPkg::OPC_OPIMM:
			begin
				ctlAluOp = rvCorePkg::ALUOP_IMM;
				ctlAluSrc = 1'b1;
				ctlRegWrite = 1'b1;
				useRs1 = 1'b1;
			end
			rvIsaPkg::OPC_LOAD:
			begin
				ctlAluSrc = 1'b1;
				ctlMemRead = 1'b1;
				ctlRegWrite = 1'b1;
				ctlMemToReg = 1'b1;
				useRs1 = 1'b1;
			end
			rvIsaPkg::OPC_STORE:
			begin
				ctlAluSrc = 1'b1;
				ctlMemWrite = 1'b1;
				useRs1 = 1'b1;
				// Store data comes from rs2
				useRs2 = 1'b1;
			end
			default: ;
		endcase
	end

	// Sign-extended I and S immediates
	always_comb
	begin
		case (opcode)
			rvIsaPkg::OPC_OPIMM, rvIsaPkg::OPC_LOAD:
				o_imm = {{20{ifIdInstr[31]}}, ifIdInstr[31:20]};
			rvIsaPkg::OPC_STORE:
				o_imm = {{20{ifIdInstr[31]}}, ifIdInstr[31:25], ifIdInstr[11:7]};
			default:
				o_imm = '0;
		endcase
	end

	// Load in EX feeding a source used here
	assign stall = i_exMemRead && (i_exRd != '0) &&
		((useRs1 && (i_exRd == o_rs1)) || (useRs2 && (i_exRd == o_rs2)));

	// Bubble into ID/EX while stalled
	assign o_aluOp = stall ? rvCorePkg::ALUOP_ADD : ctlAluOp;
	assign o_aluSrc = ctlAluSrc && !stall;
	assign o_memRead = ctlMemRead && !stall;
	assign o_memWrite = ctlMemWrite && !stall;
	assign o_regWrite = ctlRegWrite && !stall;
	assign o_memToReg = ctlMemToReg && !stall;

	// The bubble clears the load from EX, so the stall lasts one cycle
	stallSingleCycle: assert property (@(posedge clk) disable iff (i_reset)
		stall |=> !stall);

endmodule

// File: design/rvRegFile.sv
`timescale 1ns/1ps

module rvRegFile (
	input  logic clk,
	input  logic i_reset,
	input  logic [rvCorePkg::REG_IDX_W-1:0] i_rs1,
	input  logic [rvCorePkg::REG_IDX_W-1:0] i_rs2,
	input  logic i_we,
	input  logic [rvCorePkg::REG_IDX_W-1:0] i_wrIdx,
	input  logic [rvCorePkg::XLEN-1:0] i_wrData,
	output logic [rvCorePkg::XLEN-1:0] o_rdData1,
	output logic [rvCorePkg::XLEN-1:0] o_rdData2
);

	logic [rvCorePkg::XLEN-1:0] regs [2**rvCorePkg::REG_IDX_W];

	// Read with bypass of a same-cycle write
	function automatic logic [rvCorePkg::XLEN-1:0] readPort(
		input logic [rvCorePkg::REG_IDX_W-1:0] idx
	);
		if (idx == '0)
			return '0;
		else if (i_we && (idx == i_wrIdx))
			return i_wrData;
		else
			return regs[idx];
	endfunction

	always_ff @(posedge clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			for (int k = 0; k < 2**rvCorePkg::REG_IDX_W; k++)
				regs[k] <= '0;
		end
		else if (i_we && (i_wrIdx != '0))
			regs[i_wrIdx] <= i_wrData;
	end

	assign o_rdData1 = readPort(i_rs1);
	assign o_rdData2 = readPort(i_rs2);

endmodule

// File: design/rvExecute.sv
`timescale 1ns/1ps

module rvExecute (
	input  logic clk,
	input  logic i_reset,
	input  logic [rvCorePkg::REG_IDX_W-1:0] i_rs1,
	input  logic [rvCorePkg::REG_IDX_W-1:0] i_rs2,
	input  logic [rvCorePkg::REG_IDX_W-1:0] i_rd,
	input  logic [rvCorePkg::XLEN-1:0] i_imm,
	input  logic [rvCorePkg::XLEN-1:0] i_instr,
	input  rvCorePkg::aluOpT i_aluOp,
	input  logic i_aluSrc,
	input  logic i_memRead,
	input  logic i_memWrite,
	input  logic i_regWrite,
	input  logic i_memToReg,
	input  logic [rvCorePkg::XLEN-1:0] i_rdData1,
	input  logic [rvCorePkg::XLEN-1:0] i_rdData2,
	input  logic i_wbWe,
	input  logic [rvCorePkg::REG_IDX_W-1:0] i_wbRd,
	input  logic [rvCorePkg::XLEN-1:0] i_wbData,
	output logic o_memRead,
	output logic o_memWrite,
	output logic o_regWrite,
	output logic o_memToReg,
	output logic [rvCorePkg::XLEN-1:0] o_aluResult,
	output logic [rvCorePkg::XLEN-1:0] o_storeData,
	output logic [rvCorePkg::REG_IDX_W-1:0] o_rd,
	output logic o_exMemRead,
	output logic [rvCorePkg::REG_IDX_W-1:0] o_exRd
);

	rvCorePkg::aluOpT idExAluOp;
	logic idExAluSrc;
	logic idExMemRead;
	logic idExMemWrite;
	logic idExRegWrite;
	logic idExMemToReg;
	logic [rvCorePkg::REG_IDX_W-1:0] idExRs1;
	logic [rvCorePkg::REG_IDX_W-1:0] idExRs2;
	logic [rvCorePkg::REG_IDX_W-1:0] idExRd;
	logic [rvCorePkg::XLEN-1:0] idExImm;
	logic [rvCorePkg::XLEN-1:0] idExRdData1;
	logic [rvCorePkg::XLEN-1:0] idExRdData2;
	logic [rvIsaPkg::F3_W-1:0] idExFunct3;
	logic [rvIsaPkg::F7_W-1:0] idExFunct7;

	rvCorePkg::fwdSelT fwdA;
	rvCorePkg::fwdSelT fwdB;
	rvCorePkg::aluCtrlT aluCtrl;
	logic [rvCorePkg::XLEN-1:0] opA;
	logic [rvCorePkg::XLEN-1:0] opB;
	logic [rvCorePkg::XLEN-1:0] aluIn2;
	logic [rvCorePkg::XLEN-1:0] aluOut;

	// Newest producer wins, EX/MEM before MEM/WB
	function automatic rvCorePkg::fwdSelT pickFwd(
		input logic [rvCorePkg::REG_IDX_W-1:0] src
	);
		if (o_regWrite && (o_rd != '0) && (o_rd == src))
			return rvCorePkg::FWD_MEM;
		else if (i_wbWe && (i_wbRd != '0) && (i_wbRd == src))
			return rvCorePkg::FWD_WB;
		else
			return rvCorePkg::FWD_REG;
	endfunction

	function automatic logic [rvCorePkg::XLEN-1:0] fwdMux(
		input rvCorePkg::fwdSelT sel,
		input logic [rvCorePkg::XLEN-1:0] regVal
	);
		case (sel)
			rvCorePkg::FWD_MEM: return o_aluResult;
			rvCorePkg::FWD_WB: return i_wbData;
			default: return regVal;
		endcase
	endfunction

	// ID/EX control and register indices
	always_ff @(posedge clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			idExAluOp <= rvCorePkg::ALUOP_ADD;
			idExAluSrc <= 1'b0;
			idExMemRead <= 1'b0;
			idExMemWrite <= 1'b0;
			idExRegWrite <= 1'b0;
			idExMemToReg <= 1'b0;
			idExRs1 <= '0;
			idExRs2 <= '0;
			idExRd <= '0;
		end
		else
		begin
			idExAluOp <= i_aluOp;
			idExAluSrc <= i_aluSrc;
			idExMemRead <= i_memRead;
			idExMemWrite <= i_memWrite;
			idExRegWrite <= i_regWrite;
			idExMemToReg <= i_memToReg;
			idExRs1 <= i_rs1;
			idExRs2 <= i_rs2;
			idExRd <= i_rd;
		end
	end

	// ID/EX operands
	always_ff @(posedge clk)
	begin
		idExImm <= i_imm;
		idExRdData1 <= i_rdData1;
		idExRdData2 <= i_rdData2;
		idExFunct3 <= i_instr[rvIsaPkg::F3_LSB +: rvIsaPkg::F3_W];
		idExFunct7 <= i_instr[rvIsaPkg::F7_LSB +: rvIsaPkg::F7_W];
	end

	assign fwdA = pickFwd(idExRs1);
	assign fwdB = pickFwd(idExRs2);
	assign opA = fwdMux(fwdA, idExRdData1);
	assign opB = fwdMux(fwdB, idExRdData2);
	assign aluIn2 = idExAluSrc ? idExImm : opB;

	// ALU control, immediates ignore funct7
	always_comb
	begin
		aluCtrl = rvCorePkg::ALU_ADD;
		if (idExAluOp != rvCorePkg::ALUOP_ADD)
		begin
			case (idExFunct3)
				rvIsaPkg::F3_AND: aluCtrl = rvCorePkg::ALU_AND;
				rvIsaPkg::F3_OR: aluCtrl = rvCorePkg::ALU_OR;
				rvIsaPkg::F3_ADDSUB:
				begin
					if (idExAluOp == rvCorePkg::ALUOP_RTYPE && idExFunct7 == rvIsaPkg::F7_SUB)
						aluCtrl = rvCorePkg::ALU_SUB;
				end
				default: ;
			endcase
		end
	end

	always_comb
	begin
		case (aluCtrl)
			rvCorePkg::ALU_AND: aluOut = opA & aluIn2;
			rvCorePkg::ALU_OR: aluOut = opA | aluIn2;
			rvCorePkg::ALU_SUB: aluOut = opA - aluIn2;
			default: aluOut = opA + aluIn2;
		endcase
	end

	// EX/MEM control
	always_ff @(posedge clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			o_memRead <= 1'b0;
			o_memWrite <= 1'b0;
			o_regWrite <= 1'b0;
			o_memToReg <= 1'b0;
			o_rd <= '0;
		end
		else
		begin
			o_memRead <= idExMemRead;
			o_memWrite <= idExMemWrite;
			o_regWrite <= idExRegWrite;
			o_memToReg <= idExMemToReg;
			o_rd <= idExRd;
		end
	end

	// EX/MEM data, store data already forwarded
	always_ff @(posedge clk)
	begin
		o_aluResult <= aluOut;
		o_storeData <= opB;
	end

	assign o_exMemRead = idExMemRead;
	assign o_exRd = idExRd;

	// Selects depend on indices from decode and write-back
	fwdSelKnown: assert property (@(posedge clk) disable iff (i_reset)
		!$isunknown({fwdA, fwdB}));

endmodule

// File: design/rvMemWb.sv
`timescale 1ns/1ps

module rvMemWb #(
	parameter int DMEM_DEPTH = 64
) (
	input  logic clk,
	input  logic i_reset,
	input  logic i_memRead,
	input  logic i_memWrite,
	input  logic i_regWrite,
	input  logic i_memToReg,
	input  logic [rvCorePkg::XLEN-1:0] i_aluResult,
	input  logic [rvCorePkg::XLEN-1:0] i_storeData,
	input  logic [rvCorePkg::REG_IDX_W-1:0] i_rd,
	output logic o_wbWe,
	output logic [rvCorePkg::REG_IDX_W-1:0] o_wbRd,
	output logic [rvCorePkg::XLEN-1:0] o_wbData,
	output logic o_wbValid
);

	localparam int DMEM_AW = $clog2(DMEM_DEPTH);

	logic [rvCorePkg::XLEN-1:0] dmem [DMEM_DEPTH];
	logic [DMEM_AW-1:0] memIdx;
	logic [rvCorePkg::XLEN-1:0] memRdData;
	logic wbMemToReg;
	logic [rvCorePkg::XLEN-1:0] wbAluResult;
	logic [rvCorePkg::XLEN-1:0] wbLoadData;

	assign memIdx = DMEM_AW'((i_aluResult >> 2) % DMEM_DEPTH);

	// Cleared at reset so unwritten words read as zero
	always_ff @(posedge clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			for (int k = 0; k < DMEM_DEPTH; k++)
				dmem[k] <= '0;
		end
		else if (i_memWrite)
			dmem[memIdx] <= i_storeData;
	end

	assign memRdData = i_memRead ? dmem[memIdx] : '0;

	// MEM/WB control
	always_ff @(posedge clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			o_wbWe <= 1'b0;
			wbMemToReg <= 1'b0;
			o_wbRd <= '0;
		end
		else
		begin
			o_wbWe <= i_regWrite;
			wbMemToReg <= i_memToReg;
			o_wbRd <= i_rd;
		end
	end

	always_ff @(posedge clk)
	begin
		wbAluResult <= i_aluResult;
		wbLoadData <= memRdData;
	end

	assign o_wbData = wbMemToReg ? wbLoadData : wbAluResult;
	// x0 writes are not reported
	assign o_wbValid = o_wbWe && (o_wbRd != '0);

	// Decoder and bubble logic never mark both
	memRdWrExclusive: assert property (@(posedge clk) disable iff (i_reset)
		!(i_memRead && i_memWrite));

endmodule

// File: design/rvCore.sv
`timescale 1ns/1ps

module rvCore #(
	parameter int IMEM_DEPTH = 64,
	parameter int DMEM_DEPTH = 64
) (
	input  logic clk,
	input  logic i_reset,
	input  logic i_run,
	input  logic i_loadEn,
	input  logic [$clog2(IMEM_DEPTH)-1:0] i_loadAddr,
	input  logic [rvCorePkg::XLEN-1:0] i_loadData,
	output logic o_wbValid,
	output logic [rvCorePkg::REG_IDX_W-1:0] o_wbRd,
	output logic [rvCorePkg::XLEN-1:0] o_wbData
);

	// Decode stage
	logic [rvCorePkg::REG_IDX_W-1:0] idRs1;
	logic [rvCorePkg::REG_IDX_W-1:0] idRs2;
	logic [rvCorePkg::REG_IDX_W-1:0] idRd;
	logic [rvCorePkg::XLEN-1:0] idImm;
	logic [rvCorePkg::XLEN-1:0] idInstr;
	rvCorePkg::aluOpT idAluOp;
	logic idAluSrc;
	logic idMemRead;
	logic idMemWrite;
	logic idRegWrite;
	logic idMemToReg;
	logic [rvCorePkg::XLEN-1:0] rdData1;
	logic [rvCorePkg::XLEN-1:0] rdData2;

	// Hazard feedback from ID/EX
	logic exMemRead;
	logic [rvCorePkg::REG_IDX_W-1:0] exRd;

	// EX/MEM
	logic memMemRead;
	logic memMemWrite;
	logic memRegWrite;
	logic memMemToReg;
	logic [rvCorePkg::XLEN-1:0] memAluResult;
	logic [rvCorePkg::XLEN-1:0] memStoreData;
	logic [rvCorePkg::REG_IDX_W-1:0] memRd;

	// Write-back
	logic wbWe;

	rvFrontEnd #(
		.IMEM_DEPTH(IMEM_DEPTH)
	) u_frontEnd (
		.clk(clk),
		.i_reset(i_reset),
		.i_run(i_run),
		.i_loadEn(i_loadEn),
		.i_loadAddr(i_loadAddr),
		.i_loadData(i_loadData),
		.i_exMemRead(exMemRead),
		.i_exRd(exRd),
		.o_rs1(idRs1),
		.o_rs2(idRs2),
		.o_rd(idRd),
		.o_imm(idImm),
		.o_instr(idInstr),
		.o_aluOp(idAluOp),
		.o_aluSrc(idAluSrc),
		.o_memRead(idMemRead),
		.o_memWrite(idMemWrite),
		.o_regWrite(idRegWrite),
		.o_memToReg(idMemToReg)
	);

	rvRegFile u_regFile (
		.clk(clk),
		.i_reset(i_reset),
		.i_rs1(idRs1),
		.i_rs2(idRs2),
		.i_we(wbWe),
		.i_wrIdx(o_wbRd),
		.i_wrData(o_wbData),
		.o_rdData1(rdData1),
		.o_rdData2(rdData2)
	);

	rvExecute u_execute (
		.clk(clk),
		.i_reset(i_reset),
		.i_rs1(idRs1),
		.i_rs2(idRs2),
		.i_rd(idRd),
		.i_imm(idImm),
		.i_instr(idInstr),
		.i_aluOp(idAluOp),
		.i_aluSrc(idAluSrc),
		.i_memRead(idMemRead),
		.i_memWrite(idMemWrite),
		.i_regWrite(idRegWrite),
		.i_memToReg(idMemToReg),
		.i_rdData1(rdData1),
		.i_rdData2(rdData2),
		.i_wbWe(wbWe),
		.i_wbRd(o_wbRd),
		.i_wbData(o_wbData),
		.o_memRead(memMemRead),
		.o_memWrite(memMemWrite),
		.o_regWrite(memRegWrite),
		.o_memToReg(memMemToReg),
		.o_aluResult(memAluResult),
		.o_storeData(memStoreData),
		.o_rd(memRd),
		.o_exMemRead(exMemRead),
		.o_exRd(exRd)
	);

	rvMemWb #(
		.DMEM_DEPTH(DMEM_DEPTH)
	) u_memWb (
		.clk(clk),
		.i_reset(i_reset),
		.i_memRead(memMemRead),
		.i_memWrite(memMemWrite),
		.i_regWrite(memRegWrite),
		.i_memToReg(memMemToReg),
		.i_aluResult(memAluResult),
		.i_storeData(memStoreData),
		.i_rd(memRd),
		.o_wbWe(wbWe),
		.o_wbRd(o_wbRd),
		.o_wbData(o_wbData),
		.o_wbValid(o_wbValid)
	);

endmodule

// File: tb/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int PERIOD_NS = 100
) (
	output logic o_clk
);

	initial
		o_clk = 1'b0;

	// Half period per toggle
	always
		#(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

// File: tb/rvCoreChecker.sv
`timescale 1ns/1ps

module rvCoreChecker #(
	parameter int IMEM_DEPTH = 64,
	parameter int DMEM_DEPTH = 64,
	parameter int NUM_INSTR = 40
) (
	input  logic clk,
	input  logic i_reset,
	input  logic i_run,
	input  logic i_loadEn,
	input  logic [$clog2(IMEM_DEPTH)-1:0] i_loadAddr,
	input  logic [rvCorePkg::XLEN-1:0] i_loadData,
	input  logic i_wbValid,
	input  logic [rvCorePkg::REG_IDX_W-1:0] i_wbRd,
	input  logic [rvCorePkg::XLEN-1:0] i_wbData,
	input  logic i_endTest,
	output logic o_allSeen,
	output logic o_reportDone,
	output int o_errorCount
);

	localparam int CAT_ALU = 0;
	localparam int CAT_EXMEM = 1;
	localparam int CAT_MEMWB = 2;
	localparam int CAT_LOADUSE = 3;
	localparam int CAT_STLD = 4;
	localparam int CAT_X0 = 5;
	localparam int CAT_DRAIN = 6;
	localparam int NUM_CAT = 7;

	logic [rvCorePkg::XLEN-1:0] progMem [IMEM_DEPTH];
	logic [rvCorePkg::REG_IDX_W-1:0] expRd [$];
	logic [rvCorePkg::XLEN-1:0] expData [$];
	int expCat [$];
	int checks [NUM_CAT];
	int errs [NUM_CAT];
	int writeNum;
	bit modelDone;
	bit allSeenFlag;
	bit reportFlag;
	int errorTotal;

	assign o_allSeen = allSeenFlag;
	assign o_reportDone = reportFlag;
	assign o_errorCount = errorTotal;

	function automatic string catName(input int cat);
		case (cat)
			CAT_ALU: return "alu";
			CAT_EXMEM: return "exMemFwd";
			CAT_MEMWB: return "memWbFwd";
			CAT_LOADUSE: return "loadUse";
			CAT_STLD: return "storeLoad";
			CAT_X0: return "x0";
			default: return "drain";
		endcase
	endfunction

	// Program order execution, tags each write with the hazard it exercises
	task automatic runModel();
		logic [rvCorePkg::XLEN-1:0] regs [32];
		logic [rvCorePkg::XLEN-1:0] dmem [DMEM_DEPTH];
		bit stored [DMEM_DEPTH];
		logic [rvCorePkg::XLEN-1:0] w;
		logic [rvCorePkg::XLEN-1:0] a;
		logic [rvCorePkg::XLEN-1:0] b;
		logic [rvCorePkg::XLEN-1:0] res;
		logic [rvCorePkg::XLEN-1:0] immI;
		logic [rvCorePkg::XLEN-1:0] immS;
		logic [rvIsaPkg::OPC_W-1:0] opc;
		logic [rvIsaPkg::F3_W-1:0] f3;
		logic [rvIsaPkg::F7_W-1:0] f7;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] prev1;
		logic [4:0] prev2;
		logic [4:0] prevLoad;
		bit writes;
		bit useA;
		bit useB;
		bit hitStld;
		int idx;
		int cat;
		for (int k = 0; k < 32; k++)
			regs[k] = '0;
		for (int k = 0; k < DMEM_DEPTH; k++)
		begin
			dmem[k] = '0;
			stored[k] = 1'b0;
		end
		prev1 = '0;
		prev2 = '0;
		prevLoad = '0;
		for (int i = 0; i < NUM_INSTR; i++)
		begin
			w = progMem[i];
			opc = w[rvIsaPkg::OPC_LSB +: rvIsaPkg::OPC_W];
			f3 = w[rvIsaPkg::F3_LSB +: rvIsaPkg::F3_W];
			f7 = w[rvIsaPkg::F7_LSB +: rvIsaPkg::F7_W];
			rd = w[rvIsaPkg::RD_LSB +: 5];
			rs1 = w[rvIsaPkg::RS1_LSB +: 5];
			rs2 = w[rvIsaPkg::RS2_LSB +: 5];
			immI = {{20{w[31]}}, w[31:20]};
			immS = {{20{w[31]}}, w[31:25], w[11:7]};
			a = regs[rs1];
			b = regs[rs2];
			res = '0;
			writes = 1'b0;
			useA = 1'b1;
			useB = 1'b0;
			hitStld = 1'b0;
			case (opc)
				rvIsaPkg::OPC_RTYPE:
				begin
					writes = 1'b1;
					useB = 1'b1;
					case (f3)
						rvIsaPkg::F3_AND: res = a & b;
						rvIsaPkg::F3_OR: res = a | b;
						default: res = (f7 == rvIsaPkg::F7_SUB) ? a - b : a + b;
					endcase
				end
				rvIsaPkg::OPC_OPIMM:
				begin
					writes = 1'b1;
					case (f3)
						rvIsaPkg::F3_AND: res = a & immI;
						rvIsaPkg::F3_OR: res = a | immI;
						default: res = a + immI;
					endcase
				end
				rvIsaPkg::OPC_LOAD:
				begin
					writes = 1'b1;
					idx = int'(((a + immI) >> 2) % DMEM_DEPTH);
					res = dmem[idx];
					hitStld = stored[idx];
				end
				rvIsaPkg::OPC_STORE:
				begin
					useB = 1'b1;
					idx = int'(((a + immS) >> 2) % DMEM_DEPTH);
					dmem[idx] = b;
					stored[idx] = 1'b1;
				end
				default:
					useA = 1'b0;
			endcase

			// Most specific hazard wins
			cat = CAT_ALU;
			if (prev2 != '0 && ((useA && prev2 == rs1) || (useB && prev2 == rs2)))
				cat = CAT_MEMWB;
			if (prev1 != '0 && ((useA && prev1 == rs1) || (useB && prev1 == rs2)))
				cat = CAT_EXMEM;
			if (hitStld)
				cat = CAT_STLD;
			if (prevLoad != '0 && ((useA && prevLoad == rs1) || (useB && prevLoad == rs2)))
				cat = CAT_LOADUSE;

			if (writes && rd != '0)
			begin
				regs[rd] = res;
				expRd.push_back(rd);
				expData.push_back(res);
				expCat.push_back(cat);
			end
			else if (writes)
				checks[CAT_X0]++;

			prev2 = prev1;
			prev1 = (writes && rd != '0) ? rd : '0;
			prevLoad = (opc == rvIsaPkg::OPC_LOAD) ? rd : '0;
		end
	endtask

	task automatic checkWrite();
		logic [rvCorePkg::REG_IDX_W-1:0] rdExp;
		logic [rvCorePkg::XLEN-1:0] dataExp;
		int cat;
		writeNum++;
		if (i_wbRd == '0)
		begin
			errs[CAT_X0]++;
			$display("CHECK FAILED at %0t: write %0d reported to x0", $time, writeNum);
		end
		if (expRd.size() == 0)
		begin
			errs[CAT_DRAIN]++;
			$display("Unexpected register write x%0d = %h at %0t with none pending",
				i_wbRd, i_wbData, $time);
		end
		else
		begin
			rdExp = expRd.pop_front();
			dataExp = expData.pop_front();
			cat = expCat.pop_front();
			checks[cat]++;
			if (i_wbRd !== rdExp || i_wbData !== dataExp)
			begin
				errs[cat]++;
				$display("CHECK FAILED at %0t: %s write %0d expected x%0d = %h, got x%0d = %h",
					$time, catName(cat), writeNum, rdExp, dataExp, i_wbRd, i_wbData);
			end
		end
	endtask

	task automatic report();
		int totalChecks;
		int totalErrs;
		totalChecks = 0;
		totalErrs = 0;
		checks[CAT_DRAIN]++;
		if (expRd.size() != 0)
		begin
			errs[CAT_DRAIN]++;
			$display("%0d expected register writes never appeared", expRd.size());
		end
		for (int c = 0; c < NUM_CAT; c++)
		begin
			$display("Test %-10s %0d checks, %0d errors: %s", catName(c), checks[c], errs[c],
				(errs[c] == 0) ? "ok" : "FAILED");
			totalChecks += checks[c];
			totalErrs += errs[c];
		end
		$display("Totals: %0d checks, %0d errors", totalChecks, totalErrs);
		errorTotal <= totalErrs;
	endtask

	always @(posedge clk)
	begin
		if (i_loadEn)
			progMem[i_loadAddr] = i_loadData;
		if (i_run && !modelDone)
		begin
			runModel();
			modelDone = 1'b1;
		end
		if (!i_reset && i_wbValid)
			checkWrite();
		if (i_endTest && !reportFlag)
		begin
			report();
			reportFlag <= 1'b1;
		end
		allSeenFlag <= modelDone && (expRd.size() == 0);
	end

endmodule

// File: tb/rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb;

	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;
	localparam int LOAD_AW = $clog2(IMEM_DEPTH);
	localparam int NUM_INSTR = 40;
	localparam int RESET_CYCLES = 5;
	localparam int DRAIN_CYCLES = 8;
	// Reset, program load, worst-case run with every instruction stalled, drain
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + IMEM_DEPTH + 2 +
		(2 * NUM_INSTR + 20) + DRAIN_CYCLES + 4;

	logic clk;
	logic reset;
	logic run;
	logic loadEn;
	logic [LOAD_AW-1:0] loadAddr;
	logic [rvCorePkg::XLEN-1:0] loadData;
	logic wbValid;
	logic [rvCorePkg::REG_IDX_W-1:0] wbRd;
	logic [rvCorePkg::XLEN-1:0] wbData;
	logic endTest;
	logic allSeen;
	logic reportDone;
	int errorCount;
	int seed;
	int cycleCount;
	logic [rvIsaPkg::ILEN-1:0] progWords [NUM_INSTR];

	tbClock #(
		.PERIOD_NS(100)
	) u_clock (
		.o_clk(clk)
	);

	rvCore #(
		.IMEM_DEPTH(IMEM_DEPTH),
		.DMEM_DEPTH(DMEM_DEPTH)
	) i_rvCore (
		.clk(clk),
		.i_reset(reset),
		.i_run(run),
		.i_loadEn(loadEn),
		.i_loadAddr(loadAddr),
		.i_loadData(loadData),
		.o_wbValid(wbValid),
		.o_wbRd(wbRd),
		.o_wbData(wbData)
	);

	rvCoreChecker #(
		.IMEM_DEPTH(IMEM_DEPTH),
		.DMEM_DEPTH(DMEM_DEPTH),
		.NUM_INSTR(NUM_INSTR)
	) u_checker (
		.clk(clk),
		.i_reset(reset),
		.i_run(run),
		.i_loadEn(loadEn),
		.i_loadAddr(loadAddr),
		.i_loadData(loadData),
		.i_wbValid(wbValid),
		.i_wbRd(wbRd),
		.i_wbData(wbData),
		.i_endTest(endTest),
		.o_allSeen(allSeen),
		.o_reportDone(reportDone),
		.o_errorCount(errorCount)
	);

	// Places each field at its ISA position
	function automatic logic [rvIsaPkg::ILEN-1:0] packFields(
		input logic [rvIsaPkg::OPC_W-1:0] opc,
		input logic [rvCorePkg::REG_IDX_W-1:0] rd,
		input logic [rvIsaPkg::F3_W-1:0] f3,
		input logic [rvCorePkg::REG_IDX_W-1:0] rs1,
		input logic [rvCorePkg::REG_IDX_W-1:0] rs2,
		input logic [rvIsaPkg::F7_W-1:0] f7
	);
		logic [rvIsaPkg::ILEN-1:0] w;
		w = rvIsaPkg::NOP_INSTR;
		w[rvIsaPkg::OPC_LSB +: rvIsaPkg::OPC_W] = opc;
		w[rvIsaPkg::RD_LSB +: rvCorePkg::REG_IDX_W] = rd;
		w[rvIsaPkg::F3_LSB +: rvIsaPkg::F3_W] = f3;
		w[rvIsaPkg::RS1_LSB +: rvCorePkg::REG_IDX_W] = rs1;
		w[rvIsaPkg::RS2_LSB +: rvCorePkg::REG_IDX_W] = rs2;
		w[rvIsaPkg::F7_LSB +: rvIsaPkg::F7_W] = f7;
		return w;
	endfunction

	// Registers limited to x0..x7 so hazards come often
	task automatic makeInstr(output logic [rvIsaPkg::ILEN-1:0] w);
		int kind;
		logic [rvCorePkg::REG_IDX_W-1:0] rd;
		logic [rvCorePkg::REG_IDX_W-1:0] rs1;
		logic [rvCorePkg::REG_IDX_W-1:0] rs2;
		logic [11:0] imm;
		logic [11:0] memImm;
		kind = int'($unsigned($random(seed)) % 9);
		rd = 5'($unsigned($random(seed)) % 8);
		rs1 = 5'($unsigned($random(seed)) % 8);
		rs2 = 5'($unsigned($random(seed)) % 8);
		imm = 12'($random(seed));
		// Few word slots so stores and loads meet
		memImm = 12'(($unsigned($random(seed)) % 8) * 4);
		if (kind >= 7 && ($random(seed) % 2) == 0)
			rs1 = '0;
		case (kind)
			0: w = packFields(rvIsaPkg::OPC_RTYPE, rd, rvIsaPkg::F3_ADDSUB, rs1, rs2, 7'b0);
			1: w = packFields(rvIsaPkg::OPC_RTYPE, rd, rvIsaPkg::F3_ADDSUB, rs1, rs2,
				rvIsaPkg::F7_SUB);
			2: w = packFields(rvIsaPkg::OPC_RTYPE, rd, rvIsaPkg::F3_AND, rs1, rs2, 7'b0);
			3: w = packFields(rvIsaPkg::OPC_RTYPE, rd, rvIsaPkg::F3_OR, rs1, rs2, 7'b0);
			4: w = packFields(rvIsaPkg::OPC_OPIMM, rd, rvIsaPkg::F3_ADDSUB, rs1, imm[4:0],
				imm[11:5]);
			5: w = packFields(rvIsaPkg::OPC_OPIMM, rd, rvIsaPkg::F3_AND, rs1, imm[4:0],
				imm[11:5]);
			6: w = packFields(rvIsaPkg::OPC_OPIMM, rd, rvIsaPkg::F3_OR, rs1, imm[4:0],
				imm[11:5]);
			// funct3 010 is the word access
			7: w = packFields(rvIsaPkg::OPC_LOAD, rd, 3'b010, rs1, memImm[4:0], memImm[11:5]);
			default: w = packFields(rvIsaPkg::OPC_STORE, memImm[4:0], 3'b010, rs1, rs2,
				memImm[11:5]);
		endcase
	endtask

	initial
	begin
		seed = 32'h9ada;
		reset = 1'b1;
		run = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		endTest = 1'b0;
		for (int i = 0; i < NUM_INSTR; i++)
			makeInstr(progWords[i]);

		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		// Program words first and NOP words up to the memory depth
		for (int idx = 0; idx < IMEM_DEPTH; idx++)
		begin
			@(posedge clk);
			loadEn <= 1'b1;
			loadAddr <= LOAD_AW'(idx);
			loadData <= (idx < NUM_INSTR) ? progWords[idx] : rvIsaPkg::NOP_INSTR;
		end
		@(posedge clk);
		loadEn <= 1'b0;
		run <= 1'b1;

		while (!allSeen)
			@(posedge clk);
		// Stop before the PC wraps back into the program
		run <= 1'b0;
		repeat (DRAIN_CYCLES) @(posedge clk);
		endTest <= 1'b1;
		while (!reportDone)
			@(posedge clk);

		if (errorCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycleCount = cycleCount + 1;
		end
		$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: rvCore.f
design/rvIsaPkg.sv
design/rvCorePkg.sv
design/rvFrontEnd.sv
design/rvRegFile.sv
design/rvExecute.sv
design/rvMemWb.sv
design/rvCore.sv
tb/tbClock.sv
tb/rvCoreChecker.sv
tb/rvCoreTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rvCoreTb
FILELIST = rvCore.f
PASS_MSG = Simulation completed successfully
OBJDIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
